/* src/vtop_pkg.sv */
package vtop_pkg;

    // byte address, virtual before translation, physical after it
    typedef logic [31:0] addr_t;

    // one data word on either bus
    typedef logic [31:0] word_t;

    // byte write enables
    // all zero means the transfer is a read
    typedef logic [3:0] strobe_t;

    // size code as the core drives it
    typedef logic [2:0] msize_t;

    // owner of a request, port 1 or port 0
    typedef logic [0:0] port_id_t;

    // cbus burst length minus one
    typedef logic [3:0] mlen_t;

    // size codes
    localparam msize_t msize1 = 3'd0;
    localparam msize_t msize2 = 3'd1;
    localparam msize_t msize4 = 3'd2;

    // single beat, the only length used here
    localparam mlen_t mlen1 = 4'd0;

    // kernel segments
    // kseg0 cached and kseg1 uncached, both map onto the low 512 MB
    localparam addr_t kseg0_base = 32'h8000_0000;
    localparam addr_t kseg1_base = 32'hA000_0000;
    localparam addr_t seg_size = 32'h2000_0000;

    // drops the top three address bits
    localparam addr_t phys_mask = 32'h1FFF_FFFF;

    // cbus master
    // busy covers the whole time creq_valid is up
    typedef enum logic {
        master_idle,
        master_busy
    } master_state_t;

endpackage

/* src/dbus_port_stage.sv */
`timescale 1ns/1ns

module dbus_port_stage #(
    parameter vtop_pkg::port_id_t port_id = 1'b0
) (
    input  logic               clk,
    input  logic               rst,
    // request side from the core
    input  logic               req_valid,
    input  vtop_pkg::addr_t    req_addr,
    input  vtop_pkg::msize_t   req_size,
    input  vtop_pkg::strobe_t  req_strobe,
    input  vtop_pkg::word_t    req_data,
    output logic               resp_addr_ok,
    output logic               resp_data_ok,
    output vtop_pkg::word_t    resp_data,
    // held request toward the arbiter
    output logic               held_valid,
    output vtop_pkg::addr_t    held_addr,
    output vtop_pkg::msize_t   held_size,
    output vtop_pkg::strobe_t  held_strobe,
    output vtop_pkg::word_t    held_data,
    input  logic               take,
    // completion from the cbus master
    input  logic               done_valid,
    input  vtop_pkg::port_id_t done_port,
    input  vtop_pkg::word_t    done_data
);

    // set from take until the matching completion
    logic outstanding;
    logic done_hit;

    // one request per port at a time
    assign resp_addr_ok = req_valid && !held_valid && !outstanding;
    assign done_hit = done_valid && (done_port == port_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
            outstanding <= 1'b0;
            resp_data_ok <= 1'b0;
        end else begin
            resp_data_ok <= done_hit;
            if (resp_addr_ok) begin
                held_valid <= 1'b1;
            end else if (take) begin
                held_valid <= 1'b0;
            end
            // take and done never fall in the same cycle
            if (take) begin
                outstanding <= 1'b1;
            end else if (done_hit) begin
                outstanding <= 1'b0;
            end
        end
    end

    // payload, only meaningful while held or on data_ok
    always_ff @(posedge clk) begin
        if (resp_addr_ok) begin
            held_addr <= req_addr;
            held_size <= req_size;
            held_strobe <= req_strobe;
            held_data <= req_data;
        end
        if (done_hit) begin
            resp_data <= done_data;
        end
    end

endmodule

/* src/dbus_arbiter.sv */
`timescale 1ns/1ns

module dbus_arbiter (
    // port 1
    input  logic               held1_valid,
    input  vtop_pkg::addr_t    held1_addr,
    input  vtop_pkg::msize_t   held1_size,
    input  vtop_pkg::strobe_t  held1_strobe,
    input  vtop_pkg::word_t    held1_data,
    output logic               take1,
    // port 0
    input  logic               held0_valid,
    input  vtop_pkg::addr_t    held0_addr,
    input  vtop_pkg::msize_t   held0_size,
    input  vtop_pkg::strobe_t  held0_strobe,
    input  vtop_pkg::word_t    held0_data,
    output logic               take0,
    // toward the translate stage
    input  logic               fwd_ready,
    output logic               fwd_valid,
    output vtop_pkg::addr_t    fwd_addr,
    output vtop_pkg::msize_t   fwd_size,
    output vtop_pkg::strobe_t  fwd_strobe,
    output vtop_pkg::word_t    fwd_data,
    output vtop_pkg::port_id_t fwd_port
);

    // fixed priority, port 1 wins whenever it holds something
    assign fwd_valid = held1_valid || held0_valid;
    assign fwd_port = held1_valid ? 1'b1 : 1'b0;

    // field mux follows the winner
    assign fwd_addr = held1_valid ? held1_addr : held0_addr;
    assign fwd_size = held1_valid ? held1_size : held0_size;
    assign fwd_strobe = held1_valid ? held1_strobe : held0_strobe;
    assign fwd_data = held1_valid ? held1_data : held0_data;

    // take only to the winner and only if the next stage has room
    assign take1 = held1_valid && fwd_ready;
    assign take0 = held0_valid && !held1_valid && fwd_ready;

endmodule

/* src/seg_translate.sv */
`timescale 1ns/1ns

module seg_translate #(
    parameter bit seg_map_en = 1'b1
) (
    input  logic               clk,
    input  logic               rst,
    // from the arbiter
    input  logic               fwd_valid,
    input  vtop_pkg::addr_t    fwd_addr,
    input  vtop_pkg::msize_t   fwd_size,
    input  vtop_pkg::strobe_t  fwd_strobe,
    input  vtop_pkg::word_t    fwd_data,
    input  vtop_pkg::port_id_t fwd_port,
    output logic               fwd_ready,
    // toward the cbus master
    output logic               xl_valid,
    output vtop_pkg::addr_t    xl_addr,
    output vtop_pkg::msize_t   xl_size,
    output vtop_pkg::strobe_t  xl_strobe,
    output vtop_pkg::word_t    xl_data,
    output vtop_pkg::port_id_t xl_port,
    input  logic               xl_ready
);

    import vtop_pkg::*;

    addr_t phys_addr;
    logic in_kseg;
    logic load;

    // kseg0 and kseg1 are contiguous, 0x8000_0000 up to 0xBFFF_FFFF
    assign in_kseg = (fwd_addr >= kseg0_base) && (fwd_addr < kseg1_base + seg_size);

    // kuseg and kseg2/3 pass through, no tlb here
    assign phys_addr = (seg_map_en && in_kseg) ? (fwd_addr & phys_mask) : fwd_addr;

    // room when empty or when the entry leaves this cycle
    assign fwd_ready = !xl_valid || xl_ready;
    assign load = fwd_valid && fwd_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            xl_valid <= 1'b0;
        end else if (load) begin
            xl_valid <= 1'b1;
        end else if (xl_ready) begin
            xl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            xl_addr <= phys_addr;
            xl_size <= fwd_size;
            xl_strobe <= fwd_strobe;
            xl_data <= fwd_data;
            xl_port <= fwd_port;
        end
    end

endmodule

/* src/cbus_master.sv */
`timescale 1ns/1ns

module cbus_master (
    input  logic               clk,
    input  logic               rst,
    // from the translate stage
    input  logic               xl_valid,
    input  vtop_pkg::addr_t    xl_addr,
    input  vtop_pkg::msize_t   xl_size,
    input  vtop_pkg::strobe_t  xl_strobe,
    input  vtop_pkg::word_t    xl_data,
    input  vtop_pkg::port_id_t xl_port,
    output logic               xl_ready,
    // cache bus
    output logic               creq_valid,
    output logic               creq_is_write,
    output vtop_pkg::msize_t   creq_size,
    output vtop_pkg::addr_t    creq_addr,
    output vtop_pkg::strobe_t  creq_strobe,
    output vtop_pkg::word_t    creq_data,
    output vtop_pkg::mlen_t    creq_len,
    input  logic               cresp_ready,
    input  logic               cresp_last,
    input  vtop_pkg::word_t    cresp_data,
    // completion back to the port stages
    output logic               done_valid,
    output vtop_pkg::port_id_t done_port,
    output vtop_pkg::word_t    done_data
);

    import vtop_pkg::*;

    master_state_t state;
    port_id_t owner;
    logic complete;

    // single beat, so ready with last ends the transfer
    assign complete = (state == master_busy) && cresp_ready && cresp_last;

    // next entry can load in the completing cycle
    assign xl_ready = (state == master_idle) || complete;

    assign creq_valid = (state == master_busy);
    assign creq_len = mlen1;

    assign done_valid = complete;
    assign done_port = owner;
    // writes hand back zero data
    assign done_data = creq_is_write ? '0 : cresp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= master_idle;
        end else begin
            case (state)
                master_idle: begin
                    if (xl_valid) begin
                        state <= master_busy;
                    end
                end
                master_busy: begin
                    // back to back stays busy
                    if (complete && !xl_valid) begin
                        state <= master_idle;
                    end
                end
                default: state <= master_idle;
            endcase
        end
    end

    // request fields stay put while busy
    always_ff @(posedge clk) begin
        if (xl_valid && xl_ready) begin
            creq_addr <= xl_addr;
            creq_size <= xl_size;
            creq_strobe <= xl_strobe;
            creq_data <= xl_data;
            creq_is_write <= |xl_strobe;
            owner <= xl_port;
        end
    end

endmodule

/* src/vtop.sv */
`timescale 1ns/1ns

module vtop #(
    parameter bit seg_map_en = 1'b1
) (
    input  logic               clk,
    input  logic               rst,
    // data port 1
    input  logic               dreq_1_valid,
    input  vtop_pkg::addr_t    dreq_1_addr,
    input  vtop_pkg::msize_t   dreq_1_size,
    input  vtop_pkg::strobe_t  dreq_1_strobe,
    input  vtop_pkg::word_t    dreq_1_data,
    output logic               dresp_1_addr_ok,
    output logic               dresp_1_data_ok,
    output vtop_pkg::word_t    dresp_1_data,
    // data port 0
    input  logic               dreq_0_valid,
    input  vtop_pkg::addr_t    dreq_0_addr,
    input  vtop_pkg::msize_t   dreq_0_size,
    input  vtop_pkg::strobe_t  dreq_0_strobe,
    input  vtop_pkg::word_t    dreq_0_data,
    output logic               dresp_0_addr_ok,
    output logic               dresp_0_data_ok,
    output vtop_pkg::word_t    dresp_0_data,
    // cache bus master
    output logic               creq_valid,
    output logic               creq_is_write,
    output vtop_pkg::msize_t   creq_size,
    output vtop_pkg::addr_t    creq_addr,
    output vtop_pkg::strobe_t  creq_strobe,
    output vtop_pkg::word_t    creq_data,
    output vtop_pkg::mlen_t    creq_len,
    input  logic               cresp_ready,
    input  logic               cresp_last,
    input  vtop_pkg::word_t    cresp_data
);

    import vtop_pkg::*;

    // held requests
    logic held1_valid, held0_valid, take1, take0;
    addr_t held1_addr, held0_addr;
    msize_t held1_size, held0_size;
    strobe_t held1_strobe, held0_strobe;
    word_t held1_data, held0_data;

    // arbiter to translate
    logic fwd_valid, fwd_ready;
    addr_t fwd_addr;
    msize_t fwd_size;
    strobe_t fwd_strobe;
    word_t fwd_data;
    port_id_t fwd_port;

    // translate to master
    logic xl_valid, xl_ready;
    addr_t xl_addr;
    msize_t xl_size;
    strobe_t xl_strobe;
    word_t xl_data;
    port_id_t xl_port;

    // completions
    logic done_valid;
    port_id_t done_port;
    word_t done_data;

    dbus_port_stage #(.port_id(1'b1)) i_port_1 (
        .clk(clk), .rst(rst),
        .req_valid(dreq_1_valid), .req_addr(dreq_1_addr), .req_size(dreq_1_size),
        .req_strobe(dreq_1_strobe), .req_data(dreq_1_data),
        .resp_addr_ok(dresp_1_addr_ok), .resp_data_ok(dresp_1_data_ok),
        .resp_data(dresp_1_data),
        .held_valid(held1_valid), .held_addr(held1_addr), .held_size(held1_size),
        .held_strobe(held1_strobe), .held_data(held1_data), .take(take1),
        .done_valid(done_valid), .done_port(done_port), .done_data(done_data)
    );

    dbus_port_stage #(.port_id(1'b0)) i_port_0 (
        .clk(clk), .rst(rst),
        .req_valid(dreq_0_valid), .req_addr(dreq_0_addr), .req_size(dreq_0_size),
        .req_strobe(dreq_0_strobe), .req_data(dreq_0_data),
        .resp_addr_ok(dresp_0_addr_ok), .resp_data_ok(dresp_0_data_ok),
        .resp_data(dresp_0_data),
        .held_valid(held0_valid), .held_addr(held0_addr), .held_size(held0_size),
        .held_strobe(held0_strobe), .held_data(held0_data), .take(take0),
        .done_valid(done_valid), .done_port(done_port), .done_data(done_data)
    );

    dbus_arbiter i_arbiter (
        .held1_valid(held1_valid), .held1_addr(held1_addr), .held1_size(held1_size),
        .held1_strobe(held1_strobe), .held1_data(held1_data), .take1(take1),
        .held0_valid(held0_valid), .held0_addr(held0_addr), .held0_size(held0_size),
        .held0_strobe(held0_strobe), .held0_data(held0_data), .take0(take0),
        .fwd_ready(fwd_ready), .fwd_valid(fwd_valid), .fwd_addr(fwd_addr),
        .fwd_size(fwd_size), .fwd_strobe(fwd_strobe), .fwd_data(fwd_data),
        .fwd_port(fwd_port)
    );

    seg_translate #(.seg_map_en(seg_map_en)) i_translate (
        .clk(clk), .rst(rst),
        .fwd_valid(fwd_valid), .fwd_addr(fwd_addr), .fwd_size(fwd_size),
        .fwd_strobe(fwd_strobe), .fwd_data(fwd_data), .fwd_port(fwd_port),
        .fwd_ready(fwd_ready),
        .xl_valid(xl_valid), .xl_addr(xl_addr), .xl_size(xl_size),
        .xl_strobe(xl_strobe), .xl_data(xl_data), .xl_port(xl_port),
        .xl_ready(xl_ready)
    );

    cbus_master i_master (
        .clk(clk), .rst(rst),
        .xl_valid(xl_valid), .xl_addr(xl_addr), .xl_size(xl_size),
        .xl_strobe(xl_strobe), .xl_data(xl_data), .xl_port(xl_port),
        .xl_ready(xl_ready),
        .creq_valid(creq_valid), .creq_is_write(creq_is_write), .creq_size(creq_size),
        .creq_addr(creq_addr), .creq_strobe(creq_strobe), .creq_data(creq_data),
        .creq_len(creq_len),
        .cresp_ready(cresp_ready), .cresp_last(cresp_last), .cresp_data(cresp_data),
        .done_valid(done_valid), .done_port(done_port), .done_data(done_data)
    );

endmodule

/* verification/vtop_asserts.sv */
`timescale 1ns/1ns

module vtop_asserts (
    input logic              clk,
    input logic              rst,
    input logic              dreq_1_valid,
    input logic              dresp_1_addr_ok,
    input logic              dresp_1_data_ok,
    input logic              dreq_0_valid,
    input logic              dresp_0_addr_ok,
    input logic              dresp_0_data_ok,
    input logic              creq_valid,
    input logic              creq_is_write,
    input vtop_pkg::msize_t  creq_size,
    input vtop_pkg::addr_t   creq_addr,
    input vtop_pkg::strobe_t creq_strobe,
    input vtop_pkg::word_t   creq_data,
    input vtop_pkg::mlen_t   creq_len,
    input logic              cresp_ready,
    input logic              cresp_last
);

    // count of failed checks
    int unsigned failures = 0;

    // request frozen until ready and last meet
    a_creq_held: assert property (@(posedge clk) disable iff (rst)
        creq_valid && !(cresp_ready && cresp_last) |=> creq_valid &&
        $stable({creq_is_write, creq_size, creq_addr, creq_strobe, creq_data, creq_len}))
    else begin
        failures++;
        $error("creq changed before the beat was accepted");
    end

    // addr_ok only answers a valid request
    a_addr_ok_1: assert property (@(posedge clk) disable iff (rst)
        dresp_1_addr_ok |-> dreq_1_valid)
    else begin
        failures++;
        $error("dresp_1_addr_ok without dreq_1_valid");
    end

    a_addr_ok_0: assert property (@(posedge clk) disable iff (rst)
        dresp_0_addr_ok |-> dreq_0_valid)
    else begin
        failures++;
        $error("dresp_0_addr_ok without dreq_0_valid");
    end

    // data_ok is a single cycle pulse
    a_data_ok_1: assert property (@(posedge clk) disable iff (rst)
        dresp_1_data_ok |=> !dresp_1_data_ok)
    else begin
        failures++;
        $error("dresp_1_data_ok longer than one cycle");
    end

    a_data_ok_0: assert property (@(posedge clk) disable iff (rst)
        dresp_0_data_ok |=> !dresp_0_data_ok)
    else begin
        failures++;
        $error("dresp_0_data_ok longer than one cycle");
    end

endmodule

bind vtop vtop_asserts i_asserts (.*);

/* verification/tb_vtop.sv */
`timescale 1ns/1ns

module tb_vtop;

    import vtop_pkg::*;

    // about twice the worst case of all tests together
    localparam int max_cycles = 4000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic dreq_1_valid, dreq_0_valid;
    addr_t dreq_1_addr, dreq_0_addr;
    msize_t dreq_1_size, dreq_0_size;
    strobe_t dreq_1_strobe, dreq_0_strobe;
    word_t dreq_1_data, dreq_0_data;
    logic dresp_1_addr_ok, dresp_1_data_ok, dresp_0_addr_ok, dresp_0_data_ok;
    word_t dresp_1_data, dresp_0_data;
    logic creq_valid, creq_is_write;
    msize_t creq_size;
    addr_t creq_addr;
    strobe_t creq_strobe;
    word_t creq_data;
    mlen_t creq_len;
    logic cresp_ready = 1'b0;
    logic cresp_last = 1'b0;
    word_t cresp_data = '0;

    // memory model and shadow copy, 4 KB of physical space
    word_t mem [0:1023];
    word_t shadow [0:1023];
    addr_t seen_addr [$];
    integer seed = 32'h502e;
    // -1 while no beat is being timed
    int wait_left = -1;
    int cycles = 0;

    vtop #(.seg_map_en(1'b1)) i_vtop (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            fail_run($sformatf("timeout after %0d cycles, a request never completed", cycles));
        end else if (i_vtop.i_asserts.failures != 0) begin
            fail_run("a bus handshake assertion failed");
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_size(input string name, input msize_t got, input msize_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic check_len(input string name, input mlen_t got, input mlen_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, expected));
        end
    endtask

    // preload pattern, every address bit takes part
    function automatic word_t fill_word(input addr_t a);
        return a ^ {a[7:0], a[31:8]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input strobe_t strobe);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // kseg0 and kseg1 both start with 2'b10
    function automatic addr_t expected_phys(input addr_t v);
        if (v[31:30] == 2'b10) begin
            return {3'b000, v[28:0]};
        end
        return v;
    endfunction

    task automatic serve_request();
        int idx;
        if (creq_addr[31:12] != 20'h0) begin
            fail_run("cache bus access outside the memory model");
        end else begin
            idx = creq_addr[11:2];
            seen_addr.push_back(creq_addr);
            // every transfer is one word in a single beat
            check_size("creq_size", creq_size, msize4);
            check_len("creq_len", creq_len, 4'd0);
            if (creq_is_write) begin
                mem[idx] = merge_bytes(mem[idx], creq_data, creq_strobe);
                cresp_data <= '0;
            end else begin
                cresp_data <= mem[idx];
            end
            cresp_ready <= 1'b1;
            cresp_last <= 1'b1;
        end
    endtask

    // cbus slave, one beat per request after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (rst) begin
            cresp_ready <= 1'b0;
            cresp_last <= 1'b0;
            wait_left = -1;
        end else if (cresp_ready) begin
            // beat taken on this edge
            cresp_ready <= 1'b0;
            cresp_last <= 1'b0;
        end else if (creq_valid) begin
            if (wait_left < 0) begin
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                serve_request();
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic drive_req(input bit port, input bit valid, input addr_t addr,
                             input strobe_t strobe, input word_t data);
        if (port) begin
            dreq_1_valid <= valid;
            dreq_1_addr <= addr;
            dreq_1_size <= msize4;
            dreq_1_strobe <= strobe;
            dreq_1_data <= data;
        end else begin
            dreq_0_valid <= valid;
            dreq_0_addr <= addr;
            dreq_0_size <= msize4;
            dreq_0_strobe <= strobe;
            dreq_0_data <= data;
        end
    endtask

    // valid and fields stay up until addr_ok
    task automatic issue(input bit port, input addr_t addr, input strobe_t strobe,
                         input word_t data);
        logic accepted;
        @(posedge clk);
        drive_req(port, 1'b1, addr, strobe, data);
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = port ? dresp_1_addr_ok : dresp_0_addr_ok;
        end
        drive_req(port, 1'b0, '0, '0, '0);
    endtask

    task automatic wait_data(input bit port, output word_t data);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = port ? dresp_1_data_ok : dresp_0_data_ok;
        end
        data = port ? dresp_1_data : dresp_0_data;
    endtask

    task automatic dbus_write(input bit port, input addr_t addr, input strobe_t strobe,
                              input word_t data);
        addr_t phys;
        word_t returned;
        phys = expected_phys(addr);
        shadow[phys[11:2]] = merge_bytes(shadow[phys[11:2]], data, strobe);
        issue(port, addr, strobe, data);
        wait_data(port, returned);
        // a write completes with zero data
        check_word(port ? "dresp_1_data" : "dresp_0_data", returned, '0);
    endtask

    task automatic dbus_read(input bit port, input addr_t addr, output word_t data);
        issue(port, addr, 4'h0, '0);
        wait_data(port, data);
    endtask

    task automatic read_and_compare(input bit port, input addr_t addr);
        word_t data;
        addr_t phys;
        phys = expected_phys(addr);
        dbus_read(port, addr, data);
        check_word(port ? "dresp_1_data" : "dresp_0_data", data, shadow[phys[11:2]]);
    endtask

    task automatic check_seen_addr(input addr_t expected);
        if (seen_addr.size() == 0) begin
            fail_run("no cache bus request reached the memory model");
        end else begin
            check_addr("creq_addr", seen_addr.pop_front(), expected);
        end
    endtask

    task automatic test_seg_mapping();
        word_t data;
        seen_addr.delete();
        // kseg1, kseg0, then a low address that passes through
        dbus_read(1'b1, 32'hA000_0040, data);
        check_seen_addr(32'h0000_0040);
        check_word("dresp_1_data", data, fill_word(32'h0000_0040));
        dbus_read(1'b0, 32'h8000_0080, data);
        check_seen_addr(32'h0000_0080);
        check_word("dresp_0_data", data, fill_word(32'h0000_0080));
        dbus_read(1'b1, 32'h0000_00C0, data);
        check_seen_addr(32'h0000_00C0);
        check_word("dresp_1_data", data, fill_word(32'h0000_00C0));
    endtask

    task automatic test_write_read();
        dbus_write(1'b1, 32'h8000_0100, 4'hF, 32'hDEAD_BEEF);
        read_and_compare(1'b1, 32'h8000_0100);
        dbus_write(1'b0, 32'h0000_0104, 4'hF, 32'h0BAD_F00D);
        read_and_compare(1'b0, 32'h0000_0104);
    endtask

    task automatic test_byte_strobes();
        word_t data;
        dbus_write(1'b0, 32'h0000_0200, 4'b0101, 32'h1122_3344);
        dbus_read(1'b0, 32'h0000_0200, data);
        check_word("dresp_0_data", data,
                   merge_bytes(fill_word(32'h0000_0200), 32'h1122_3344, 4'b0101));
        dbus_write(1'b1, 32'hA000_0204, 4'b1000, 32'h99AA_BBCC);
        dbus_read(1'b1, 32'hA000_0204, data);
        check_word("dresp_1_data", data,
                   merge_bytes(fill_word(32'h0000_0204), 32'h99AA_BBCC, 4'b1000));
    endtask

    // both valid in the same cycle, port 1 reaches the bus first
    task automatic test_simultaneous();
        word_t d1;
        word_t d0;
        seen_addr.delete();
        fork
            dbus_read(1'b1, 32'h8000_0010, d1);
            dbus_read(1'b0, 32'h0000_0014, d0);
        join
        check_seen_addr(32'h0000_0010);
        check_seen_addr(32'h0000_0014);
        check_word("dresp_1_data", d1, shadow[4]);
        check_word("dresp_0_data", d0, shadow[5]);
    endtask

    // 100 ops on one port over 16 words of its own
    task automatic random_port(input bit port, input addr_t base);
        addr_t addr;
        strobe_t strobe;
        word_t data;
        for (int n = 0; n < 100; n++) begin
            addr = base + (($unsigned($random(seed)) % 16) << 2);
            if ($random(seed) & 1) begin
                strobe = $random(seed);
                if (strobe == 4'h0) begin
                    strobe = 4'hF;
                end
                data = $random(seed);
                dbus_write(port, addr, strobe, data);
            end else begin
                read_and_compare(port, addr);
            end
        end
    endtask

    task automatic test_random_traffic();
        fork
            random_port(1'b1, 32'hA000_0300);
            random_port(1'b0, 32'h0000_0340);
        join
    endtask

    initial begin
        drive_req(1'b1, 1'b0, '0, '0, '0);
        drive_req(1'b0, 1'b0, '0, '0, '0);
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(addr_t'(i) << 2);
            shadow[i] = mem[i];
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_seg_mapping();
        test_write_read();
        test_byte_strobes();
        test_simultaneous();
        test_random_traffic();
        repeat (4) @(posedge clk);
        if (i_vtop.i_asserts.failures == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_run("bus handshake assertions failed during the run");
        end
    end

endmodule

/* sources.f */
src/vtop_pkg.sv
src/dbus_port_stage.sv
src/dbus_arbiter.sv
src/seg_translate.sv
src/cbus_master.sv
src/vtop.sv
verification/vtop_asserts.sv
verification/tb_vtop.sv

/* Bender.yml */
package:
  name: vtop

sources:
  - files:
      - src/vtop_pkg.sv
      - src/dbus_port_stage.sv
      - src/dbus_arbiter.sv
      - src/seg_translate.sv
      - src/cbus_master.sv
      - src/vtop.sv
  - target: test
    files:
      - verification/vtop_asserts.sv
      - verification/tb_vtop.sv
